//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= tb_axi_write_packet_slave
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+src
src/ll_pkg.sv
src/ll_online_delay.sv
src/ll_receive.sv
src/ll_transmit.sv
src/axi_write_packet_slave_top.sv
sim/tb_axi_write_packet_slave.sv

//--- sim/tb_axi_write_packet_slave.sv
/* Testbench for the AXI write packet slave: directed tests of the
   online delay, the AW and W receive FIFOs and the B credit flow */
`include "ll_consts.svh"

module tb_axi_write_packet_slave;
  timeunit 1ns;
  timeprecision 1ps;

  import ll_pkg::*;

  localparam int CLK_PERIOD = 20;
  // Reset, delay, delivery, fill, B credits, reload
  localparam int BUDGET_CYCLES = 4 + 12 + 200 + 40 + 20 + 20;
  localparam int MARGIN_CYCLES = 100;

  logic                    clk;
  logic                    reset;
  logic                    tx_online;
  logic                    rx_online;
  delay_t                  delay_x_value;
  delay_t                  delay_y_value;
  cred_cnt_t               init_b_credit;
  logic [`LL_RX_PHY_W-1:0] rx_phy;
  logic [`LL_TX_PHY_W-1:0] tx_phy;
  axi_id_t                 user_awid;
  logic [`LL_LEN_W-1:0]    user_awlen;
  axi_addr_t               user_awaddr;
  logic                    user_awvalid;
  logic                    user_awready;
  axi_id_t                 user_wid;
  axi_data_t               user_wdata;
  logic [`LL_STRB_W-1:0]   user_wstrb;
  logic                    user_wlast;
  logic                    user_wvalid;
  logic                    user_wready;
  axi_id_t                 user_bid;
  logic [`LL_RESP_W-1:0]   user_bresp;
  logic                    user_bvalid;
  logic                    user_bready;

  logic [31:0] lcg_state  = 32'd82;
  int          aw_credits = 0;
  int          w_credits  = 0;
  aw_pkt_t     exp_aw [$];
  w_pkt_t      exp_w  [$];

  axi_write_packet_slave_top uut (.clk_wr(clk), .*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Credit pulses as the remote master sees them
  always @(negedge clk) begin
    if (tx_phy[`LL_TX_AW_CRED]) begin
      aw_credits++;
    end
    if (tx_phy[`LL_TX_W_CRED]) begin
      w_credits++;
    end
  end

  initial begin
    #((BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("TESTS FAILED");
    $fatal(1, "Watchdog expired");
  end

  //////////////////////////////////////////
  // Helpers

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // id, len, addr
  function automatic aw_pkt_t random_aw();
    logic [31:0] r;
    r = next_random();
    return {r[31:28], r[27:20], r[19:4]};
  endfunction

  // id, data, strb, last
  function automatic w_pkt_t random_w();
    logic [31:0] r;
    logic [31:0] d;
    r = next_random();
    d = next_random();
    return {r[31:28], d, r[27:24], r[23]};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Receive PHY word, bit 0 upward
  task automatic drive_rx_phy(input logic aw_push, input aw_pkt_t aw_pkt, input logic w_push,
                              input w_pkt_t w_pkt, input logic b_cred);
    rx_phy = {b_cred, w_pkt, w_push, aw_pkt, aw_push};
  endtask

  task automatic check_aw(input aw_pkt_t pkt);
    check_value("user_awid", user_awid, pkt[27:24]);
    check_value("user_awlen", user_awlen, pkt[23:16]);
    check_value("user_awaddr", user_awaddr, pkt[15:0]);
  endtask

  task automatic check_w(input w_pkt_t pkt);
    check_value("user_wid", user_wid, pkt[40:37]);
    check_value("user_wdata", user_wdata, pkt[36:5]);
    check_value("user_wstrb", user_wstrb, pkt[4:1]);
    check_value("user_wlast", user_wlast, pkt[0]);
  endtask

  // Holds bvalid until the handshake, then checks the PHY word
  task automatic send_b(input axi_id_t id, input logic [1:0] resp);
    logic ready;
    user_bid    = id;
    user_bresp  = resp;
    user_bvalid = 1'b1;
    ready       = 1'b0;
    while (!ready) begin
      ready = user_bready;
      next_cycle();
      check_value("tx_phy b pushbit", tx_phy[`LL_TX_B_PUSH], ready);
    end
    check_value("tx_phy b packet", tx_phy[`LL_TX_B_LSB +: `LL_B_W], {id, resp});
    user_bvalid = 1'b0;
  endtask

  //////////////////////////////////////////
  // Tests

  task automatic test_reset_state();
    check_value("user_awvalid", user_awvalid, 1'b0);
    check_value("user_wvalid", user_wvalid, 1'b0);
    check_value("user_bready", user_bready, 1'b0);
    check_value("tx_phy", tx_phy, '0);
  endtask

  task automatic test_online_delay();
    aw_pkt_t pkt;
    rx_online = 1'b1;
    // Pushes on the six hold-off edges are dropped
    for (int i = 0; i < 6; i++) begin
      drive_rx_phy(1'b1, random_aw(), 1'b0, '0, 1'b0);
      next_cycle();
      check_value("user_awvalid", user_awvalid, 1'b0);
    end
    pkt = random_aw();
    drive_rx_phy(1'b1, pkt, 1'b0, '0, 1'b0);
    next_cycle();
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b0);
    check_value("user_awvalid", user_awvalid, 1'b1);
    check_aw(pkt);
    user_awready = 1'b1;
    next_cycle();
    user_awready = 1'b0;
    check_value("user_awvalid", user_awvalid, 1'b0);
    check_value("tx_phy aw credit", tx_phy[`LL_TX_AW_CRED], 1'b1);
    next_cycle();
    check_value("tx_phy aw credit", tx_phy[`LL_TX_AW_CRED], 1'b0);
  endtask

  task automatic test_aw_w_delivery();
    int          aw_sent   = 0;
    int          w_sent    = 0;
    int          aw_popped = 0;
    int          w_popped  = 0;
    int          aw_base;
    int          w_base;
    logic        aw_push;
    logic        w_push;
    logic [31:0] r;
    aw_pkt_t     aw_pkt;
    w_pkt_t      w_pkt;
    aw_base = aw_credits;
    w_base  = w_credits;
    while (aw_popped < 10 || w_popped < 20) begin
      check_value("user_awvalid", user_awvalid, exp_aw.size() != 0);
      check_value("user_wvalid", user_wvalid, exp_w.size() != 0);
      if (user_awvalid) begin
        check_aw(exp_aw[0]);
      end
      if (user_wvalid) begin
        check_w(exp_w[0]);
      end
      // Queue size is the FIFO occupancy before the next edge
      r            = next_random();
      aw_push      = (aw_sent < 10) && (exp_aw.size() < `LL_AW_DEPTH) && r[31];
      w_push       = (w_sent < 20) && (exp_w.size() < `LL_W_DEPTH) && r[30];
      user_awready = r[29];
      user_wready  = r[28];
      if (user_awvalid && user_awready) begin
        void'(exp_aw.pop_front());
        aw_popped++;
      end
      if (user_wvalid && user_wready) begin
        void'(exp_w.pop_front());
        w_popped++;
      end
      aw_pkt = random_aw();
      w_pkt  = random_w();
      if (aw_push) begin
        exp_aw.push_back(aw_pkt);
        aw_sent++;
      end
      if (w_push) begin
        exp_w.push_back(w_pkt);
        w_sent++;
      end
      drive_rx_phy(aw_push, aw_pkt, w_push, w_pkt, 1'b0);
      next_cycle();
    end
    check_value("user_awvalid", user_awvalid, 1'b0);
    check_value("user_wvalid", user_wvalid, 1'b0);
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b0);
    user_awready = 1'b0;
    user_wready  = 1'b0;
    repeat (2) next_cycle();
    check_value("aw credit pulses", aw_credits - aw_base, aw_popped);
    check_value("w credit pulses", w_credits - w_base, w_popped);
  endtask

  task automatic test_fifo_fill_hold();
    w_pkt_t pkt;
    user_wready = 1'b0;
    for (int i = 0; i < `LL_W_DEPTH; i++) begin
      pkt = random_w();
      exp_w.push_back(pkt);
      drive_rx_phy(1'b0, '0, 1'b1, pkt, 1'b0);
      next_cycle();
      check_value("user_wvalid", user_wvalid, 1'b1);
      check_w(exp_w[0]);
    end
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b0);
    repeat (3) begin
      next_cycle();
      check_value("user_wvalid", user_wvalid, 1'b1);
      check_w(exp_w[0]);
    end
    user_wready = 1'b1;
    for (int i = 0; i < `LL_W_DEPTH; i++) begin
      check_value("user_wvalid", user_wvalid, 1'b1);
      check_w(exp_w.pop_front());
      next_cycle();
    end
    user_wready = 1'b0;
    // Drained without a seventeenth push
    check_value("user_wvalid", user_wvalid, 1'b0);
  endtask

  task automatic test_b_credits();
    logic [31:0] r;
    init_b_credit = 8'd2;
    tx_online     = 1'b1;
    next_cycle();
    check_value("user_bready", user_bready, 1'b1);
    for (int i = 0; i < 2; i++) begin
      r = next_random();
      send_b(r[31:28], r[27:26]);
    end
    check_value("user_bready", user_bready, 1'b0);
    // Third response waits for a credit
    r           = next_random();
    user_bid    = r[31:28];
    user_bresp  = r[27:26];
    user_bvalid = 1'b1;
    repeat (3) begin
      next_cycle();
      check_value("user_bready", user_bready, 1'b0);
      check_value("tx_phy b pushbit", tx_phy[`LL_TX_B_PUSH], 1'b0);
    end
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b1);
    next_cycle();
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b0);
    check_value("user_bready", user_bready, 1'b1);
    send_b(r[31:28], r[27:26]);
    check_value("user_bready", user_bready, 1'b0);
  endtask

  task automatic test_credit_reload();
    logic [31:0] r;
    // One spare credit so ready is high when the link drops
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b1);
    next_cycle();
    drive_rx_phy(1'b0, '0, 1'b0, '0, 1'b0);
    check_value("user_bready", user_bready, 1'b1);
    tx_online     = 1'b0;
    init_b_credit = 8'd3;
    repeat (4) begin
      next_cycle();
      check_value("user_bready", user_bready, 1'b0);
    end
    tx_online = 1'b1;
    next_cycle();
    check_value("user_bready", user_bready, 1'b1);
    for (int i = 0; i < 3; i++) begin
      r = next_random();
      send_b(r[31:28], r[27:26]);
    end
    check_value("user_bready", user_bready, 1'b0);
  endtask

  initial begin
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = 16'd5;
    delay_y_value = 16'd0;
    init_b_credit = 8'd2;
    rx_phy        = '0;
    user_awready  = 1'b0;
    user_wready   = 1'b0;
    user_bid      = '0;
    user_bresp    = '0;
    user_bvalid   = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_state();
    test_online_delay();
    test_aw_w_delivery();
    test_fifo_fill_hold();
    test_b_credits();
    test_credit_reload();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- src/axi_write_packet_slave_top.sv
/* AXI write packet slave: receives AW and W packets from the PHY and
   returns B responses and channel credits to the remote master */
`include "ll_consts.svh"

module axi_write_packet_slave_top (
  input  logic                      clk_wr,
  input  logic                      reset,

  // Link control
  input  logic                      tx_online,
  input  logic                      rx_online,
  input  ll_pkg::delay_t            delay_x_value,
  input  ll_pkg::delay_t            delay_y_value,
  input  ll_pkg::cred_cnt_t         init_b_credit,

  // PHY
  input  logic [`LL_RX_PHY_W-1:0]   rx_phy,
  output logic [`LL_TX_PHY_W-1:0]   tx_phy,

  // AW channel
  output ll_pkg::axi_id_t           user_awid,
  output logic [`LL_LEN_W-1:0]      user_awlen,
  output ll_pkg::axi_addr_t         user_awaddr,
  output logic                      user_awvalid,
  input  logic                      user_awready,

  // W channel
  output ll_pkg::axi_id_t           user_wid,
  output ll_pkg::axi_data_t         user_wdata,
  output logic [`LL_STRB_W-1:0]     user_wstrb,
  output logic                      user_wlast,
  output logic                      user_wvalid,
  input  logic                      user_wready,

  // B channel
  input  ll_pkg::axi_id_t           user_bid,
  input  logic [`LL_RESP_W-1:0]     user_bresp,
  input  logic                      user_bvalid,
  output logic                      user_bready
);

  import ll_pkg::*;

  logic    rx_online_dly;
  logic    tx_online_dly;

  logic    rx_aw_pushbit;
  aw_pkt_t rx_aw_data;
  aw_pkt_t user_aw_data;
  logic    tx_aw_credit;

  logic    rx_w_pushbit;
  w_pkt_t  rx_w_data;
  w_pkt_t  user_w_data;
  logic    tx_w_credit;

  b_pkt_t  user_b_data;
  logic    tx_b_pushbit;
  b_pkt_t  tx_b_data;
  logic    rx_b_credit;

  ////////////////////////////////////////
  // Online delay

  ll_online_delay u_online_delay (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .rx_online     (rx_online),
    .tx_online     (tx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .rx_online_dly (rx_online_dly),
    .tx_online_dly (tx_online_dly)
  );

  ////////////////////////////////////////
  // Link channels

  ll_receive #(.WIDTH(`LL_AW_W), .DEPTH(`LL_AW_DEPTH)) u_rx_aw (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .online     (rx_online_dly),
    .rx_pushbit (rx_aw_pushbit),
    .rx_data    (rx_aw_data),
    .tx_credit  (tx_aw_credit),
    .user_valid (user_awvalid),
    .user_data  (user_aw_data),
    .user_ready (user_awready)
  );

  ll_receive #(.WIDTH(`LL_W_W), .DEPTH(`LL_W_DEPTH)) u_rx_w (
    .clk_wr     (clk_wr),
    .reset      (reset),
    .online     (rx_online_dly),
    .rx_pushbit (rx_w_pushbit),
    .rx_data    (rx_w_data),
    .tx_credit  (tx_w_credit),
    .user_valid (user_wvalid),
    .user_data  (user_w_data),
    .user_ready (user_wready)
  );

  ll_transmit #(.WIDTH(`LL_B_W)) u_tx_b (
    .clk_wr      (clk_wr),
    .reset       (reset),
    .online      (tx_online_dly),
    .init_credit (init_b_credit),
    .rx_credit   (rx_b_credit),
    .user_valid  (user_bvalid),
    .user_data   (user_b_data),
    .user_ready  (user_bready),
    .tx_pushbit  (tx_b_pushbit),
    .tx_data     (tx_b_data)
  );

  ////////////////////////////////////////
  // PHY word mapping

  assign rx_aw_pushbit = rx_phy[`LL_RX_AW_PUSH];
  assign rx_aw_data    = rx_phy[`LL_RX_AW_LSB +: `LL_AW_W];
  assign rx_w_pushbit  = rx_phy[`LL_RX_W_PUSH];
  assign rx_w_data     = rx_phy[`LL_RX_W_LSB +: `LL_W_W];
  assign rx_b_credit   = rx_phy[`LL_RX_B_CRED];

  always_comb begin
    tx_phy                              = '0;
    tx_phy[`LL_TX_B_PUSH]               = tx_b_pushbit;
    tx_phy[`LL_TX_B_LSB +: `LL_B_W]     = tx_b_data;
    tx_phy[`LL_TX_AW_CRED]              = tx_aw_credit;
    tx_phy[`LL_TX_W_CRED]               = tx_w_credit;
  end

  ////////////////////////////////////////
  // AXI field packing, first field in the MSBs

  assign {user_awid, user_awlen, user_awaddr}          = user_aw_data;
  assign {user_wid, user_wdata, user_wstrb, user_wlast} = user_w_data;
  assign user_b_data                                    = {user_bid, user_bresp};

endmodule

//--- src/ll_consts.svh
/* Logic link constants: AXI field widths, packet widths, FIFO depths
   and bit positions inside the receive and transmit PHY words */
`ifndef LL_CONSTS_SVH
`define LL_CONSTS_SVH

`define LL_ADDR_W       16
`define LL_DATA_W       32
`define LL_STRB_W       4
`define LL_ID_W         4
`define LL_LEN_W        8
`define LL_RESP_W       2
`define LL_AW_W         28
`define LL_W_W          41
`define LL_B_W          6
`define LL_RX_PHY_W     72
`define LL_TX_PHY_W     9
`define LL_AW_DEPTH     8
`define LL_W_DEPTH      16
`define LL_CRED_W       8
`define LL_DELAY_W      16

// Receive PHY word, bit 0 upward
`define LL_RX_AW_PUSH   0
`define LL_RX_AW_LSB    1
`define LL_RX_W_PUSH    29
`define LL_RX_W_LSB     30
`define LL_RX_B_CRED    71

// Transmit PHY word
`define LL_TX_B_PUSH    0
`define LL_TX_B_LSB     1
`define LL_TX_AW_CRED   7
`define LL_TX_W_CRED    8

`endif

//--- src/ll_online_delay.sv
/* Online delay: holds off rx and tx online until each has stayed
   high for its programmed number of cycles */
module ll_online_delay (
  input  logic           clk_wr,
  input  logic           reset,

  input  logic           rx_online,
  input  logic           tx_online,
  input  ll_pkg::delay_t delay_x_value,
  input  ll_pkg::delay_t delay_y_value,

  output logic           rx_online_dly,
  output logic           tx_online_dly
);

  import ll_pkg::*;

  // Index 0 is rx, index 1 is tx
  logic [1:0] online_in;
  logic [1:0] online_dly;
  delay_t     limit [2];
  delay_t     cnt   [2];

  assign online_in = {tx_online, rx_online};
  assign limit[0]  = delay_x_value;
  assign limit[1]  = delay_y_value;

  ////////////////////////////////////////
  // Saturating hold-off counters

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      for (int i = 0; i < 2; i++) begin
        cnt[i]        <= '0;
        online_dly[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!online_in[i]) begin
          // Drop straight away, restart the wait
          cnt[i]        <= '0;
          online_dly[i] <= 1'b0;
        end else if (cnt[i] >= limit[i]) begin
          online_dly[i] <= 1'b1;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign rx_online_dly = online_dly[0];
  assign tx_online_dly = online_dly[1];

endmodule

//--- src/ll_pkg.sv
/* Logic link types shared by the write packet slave */
`include "ll_consts.svh"

package ll_pkg;

  //////////////////////////////////////////
  // Packet vectors

  // id, len, addr from the MSB down
  typedef logic [`LL_AW_W-1:0]    aw_pkt_t;
  // id, data, strb, last
  typedef logic [`LL_W_W-1:0]     w_pkt_t;
  // id, resp
  typedef logic [`LL_B_W-1:0]     b_pkt_t;

  //////////////////////////////////////////
  // AXI fields

  typedef logic [`LL_ADDR_W-1:0]  axi_addr_t;
  typedef logic [`LL_DATA_W-1:0]  axi_data_t;
  typedef logic [`LL_ID_W-1:0]    axi_id_t;

  //////////////////////////////////////////
  // Counters

  typedef logic [`LL_CRED_W-1:0]  cred_cnt_t;
  typedef logic [`LL_DELAY_W-1:0] delay_t;

endpackage

//--- src/ll_receive.sv
/* Receive side of one link channel: buffers PHY pushes in a FIFO and
   returns one credit to the remote sender for every user pop */
module ll_receive #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk_wr,
  input  logic             reset,

  input  logic             online,

  // PHY side
  input  logic             rx_pushbit,
  input  logic [WIDTH-1:0] rx_data,
  output logic             tx_credit,

  // User side, show-ahead
  output logic             user_valid,
  output logic [WIDTH-1:0] user_data,
  input  logic             user_ready
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  // Wrap at DEPTH so non power of two depths work
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full = (count == CNT_W'(DEPTH));

  // Pushes while offline or full are dropped
  assign push = online & rx_pushbit & ~full;
  assign pop  = user_valid & user_ready;

  assign user_valid = (count != '0);
  assign user_data  = mem[rd_ptr];

  ////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr] <= rx_data;
    end
  end

  ////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // Credit return

  // One pulse per freed entry
  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_credit <= 1'b0;
    end else begin
      tx_credit <= pop;
    end
  end

endmodule

//--- src/ll_transmit.sv
/* Transmit side of one link channel: sends user packets onto the PHY
   while the remote receiver has credit left */
module ll_transmit #(
  parameter int WIDTH = 8
) (
  input  logic              clk_wr,
  input  logic              reset,

  input  logic              online,
  input  ll_pkg::cred_cnt_t init_credit,

  // Credit pulse from the remote receiver
  input  logic              rx_credit,

  // User side
  input  logic              user_valid,
  input  logic [WIDTH-1:0]  user_data,
  output logic              user_ready,

  // PHY side
  output logic              tx_pushbit,
  output logic [WIDTH-1:0]  tx_data
);

  import ll_pkg::*;

  cred_cnt_t credit_cnt;
  logic      send;

  assign user_ready = online & (credit_cnt != '0);
  assign send       = user_valid & user_ready;

  ////////////////////////////////////////
  // Credit count

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      credit_cnt <= '0;
    end else if (!online) begin
      // Remote FIFO is empty again once the link comes back
      credit_cnt <= init_credit;
    end else begin
      case ({rx_credit, send})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  ////////////////////////////////////////
  // PHY register

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_pushbit <= 1'b0;
      tx_data    <= '0;
    end else begin
      tx_pushbit <= send;
      // Idle slots carry zeros
      tx_data    <= send ? user_data : '0;
    end
  end

endmodule
